/* build.f */
src/exe_pkg.sv
src/exe_dispatch.sv
src/alu.sv
src/mul_unit.sv
src/wb_arbiter.sv
src/exe_cluster.sv
test/tb_clk_gen.sv
test/tb_exe_cluster.sv

/* run_sim.sh */
#!/bin/sh
# build the execution cluster testbench with Verilator, run it, look for the pass line
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_exe_cluster -o sim_exe \
    && ./obj_dir/sim_exe | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "simulation run ok" \
    || { echo "simulation run not ok"; exit 1; }

/* src/alu.sv */
// combinational RV64I integer ALU
// register-register ops, W forms and system pass-through

module alu
    import exe_pkg::*;
(
    input  rr_exe_instr_t instruction_i,
    output exe_wb_instr_t instruction_o
);

    bus64_t      rs1;
    bus64_t      rs2;
    bus64_t      result;
    logic [31:0] res_w;    // low word of the W forms
    logic        is_w;

    assign rs1 = instruction_i.data_rs1;
    assign rs2 = instruction_i.data_rs2;

    always_comb begin
        result = '0;
        res_w  = '0;
        is_w   = 1'b0;
        case (instruction_i.instr_type)
            ADD: result = rs1 + rs2;
            ADDW: begin
                res_w = rs1[31:0] + rs2[31:0];
                is_w  = 1'b1;
            end
            SUB: result = rs1 - rs2;
            SUBW: begin
                res_w = rs1[31:0] - rs2[31:0];
                is_w  = 1'b1;
            end
            SLL: result = rs1 << rs2[5:0];
            SLLW: begin
                res_w = rs1[31:0] << rs2[4:0];   // 5-bit shamt
                is_w  = 1'b1;
            end
            SLT:  result = {63'b0, $signed(rs1) < $signed(rs2)};
            SLTU: result = {63'b0, rs1 < rs2};
            XOR:  result = rs1 ^ rs2;
            SRL:  result = rs1 >> rs2[5:0];
            SRLW: begin
                res_w = rs1[31:0] >> rs2[4:0];
                is_w  = 1'b1;
            end
            SRA: result = $signed(rs1) >>> rs2[5:0];
            SRAW: begin
                res_w = $signed(rs1[31:0]) >>> rs2[4:0];
                is_w  = 1'b1;
            end
            OR:  result = rs1 | rs2;
            AND: result = rs1 & rs2;
            default: begin
                // CSR writes need the old rs1 value downstream
                if (instruction_i.unit == UNIT_SYSTEM) begin
                    result = rs1;
                end else begin
                    result = '0;
                end
            end
        endcase

        if (is_w) begin
            result = {{32{res_w[31]}}, res_w};   // sign extend bit 31
        end
    end

    // writeback record, metadata copied through
    always_comb begin
        instruction_o.valid      = instruction_i.valid &
                                   ((instruction_i.unit == UNIT_ALU) |
                                    (instruction_i.unit == UNIT_SYSTEM));
        instruction_o.pc         = instruction_i.pc;
        instruction_o.rd         = instruction_i.rd;
        instruction_o.regfile_we = instruction_i.regfile_we;
        instruction_o.gl_index   = instruction_i.gl_index;
        instruction_o.instr_type = instruction_i.instr_type;
        instruction_o.result     = result;
    end

endmodule

/* src/exe_cluster.sv */
// top level of the integer execution cluster
// dispatch register, ALU, multiplier and writeback arbiter

module exe_cluster
    import exe_pkg::*;
#(
    parameter int MUL_RADIX_BITS = 2   // 1, 2 or 4
) (
    input  logic          clk_i,
    input  logic          arst_n_i,
    input  rr_exe_instr_t rr_instr_i,
    output logic          stall_o,
    output exe_wb_instr_t wb_o
);

    rr_exe_instr_t alu_instr;
    rr_exe_instr_t mul_instr;
    exe_wb_instr_t alu_wb;
    exe_wb_instr_t mul_wb;
    logic          alu_slot_free;
    logic          mul_busy;
    logic          mul_grant;

    exe_dispatch i_dispatch (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .rr_instr_i      (rr_instr_i),
        .alu_slot_free_i (alu_slot_free),
        .mul_busy_i      (mul_busy),
        .alu_instr_o     (alu_instr),
        .mul_instr_o     (mul_instr),
        .stall_o         (stall_o)
    );

    alu i_alu (
        .instruction_i (alu_instr),
        .instruction_o (alu_wb)
    );

    mul_unit #(
        .MUL_RADIX_BITS (MUL_RADIX_BITS)
    ) i_mul (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .instr_i  (mul_instr),
        .grant_i  (mul_grant),
        .busy_o   (mul_busy),
        .wb_o     (mul_wb)
    );

    wb_arbiter i_arbiter (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .alu_wb_i        (alu_wb),
        .mul_wb_i        (mul_wb),
        .alu_slot_free_o (alu_slot_free),
        .mul_grant_o     (mul_grant),
        .wb_o            (wb_o)
    );

endmodule

/* src/exe_dispatch.sv */
// dispatch register of the execution cluster
// holds one instruction, routes it to the ALU or the multiplier
// and stalls read-register while the target is busy

module exe_dispatch
    import exe_pkg::*;
(
    input  logic          clk_i,
    input  logic          arst_n_i,
    input  rr_exe_instr_t rr_instr_i,        // from read-register
    input  logic          alu_slot_free_i,   // ALU result slot can take one
    input  logic          mul_busy_i,
    output rr_exe_instr_t alu_instr_o,
    output rr_exe_instr_t mul_instr_o,
    output logic          stall_o
);

    logic          full_q;     // register holds an instruction
    rr_exe_instr_t instr_q;
    logic          tgt_mul;    // target decoded from unit field
    logic          can_fire;
    logic          fire;

    // ALU and SYSTEM both go through the ALU
    assign tgt_mul  = (instr_q.unit == UNIT_MUL);
    assign can_fire = tgt_mul ? ~mul_busy_i : alu_slot_free_i;
    assign fire     = full_q & can_fire;

    // full and the target refuses, so keep the instruction
    assign stall_o  = full_q & ~can_fire;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_q <= 1'b0;
        end else if (!stall_o) begin
            full_q <= rr_instr_i.valid;   // empties on fire unless refilled
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_o && rr_instr_i.valid) begin
            instr_q <= rr_instr_i;
        end
    end

    // valid only in the cycle the instruction leaves
    always_comb begin
        alu_instr_o       = instr_q;
        alu_instr_o.valid = fire & ~tgt_mul;
        mul_instr_o       = instr_q;
        mul_instr_o.valid = fire & tgt_mul;
    end

endmodule

/* src/exe_pkg.sv */
// shared widths, enums and structs of the integer execution cluster
// unit select and opcode enums
// read-register instruction and writeback records

package exe_pkg;

    localparam int XLEN    = 64;
    localparam int REG_W   = 5;
    localparam int GL_W    = 6;   // reorder-buffer tag width
    localparam int PC_W    = 40;
    localparam int OP_W    = 6;

    typedef logic [XLEN-1:0]  bus64_t;
    typedef logic [REG_W-1:0] reg_t;
    typedef logic [GL_W-1:0]  gl_index_t;

    // functional unit that executes the instruction
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_SYSTEM
    } unit_t;

    typedef enum logic [OP_W-1:0] {
        ADD,
        ADDW,
        SUB,
        SUBW,
        SLL,
        SLLW,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRLW,
        SRA,
        SRAW,
        OR,
        AND,
        MUL,
        MULW,
        MULHU,
        CSRRW     // system path only
    } instr_type_t;

    // one instruction from read-register, operands already read
    typedef struct packed {
        logic              valid;
        unit_t             unit;
        instr_type_t       instr_type;
        logic [PC_W-1:0]   pc;
        reg_t              rd;
        logic              regfile_we;
        gl_index_t         gl_index;
        bus64_t            data_rs1;
        bus64_t            data_rs2;
    } rr_exe_instr_t;

    // one result on its way to the register file
    typedef struct packed {
        logic              valid;
        logic [PC_W-1:0]   pc;
        reg_t              rd;
        logic              regfile_we;
        gl_index_t         gl_index;
        instr_type_t       instr_type;
        bus64_t            result;
    } exe_wb_instr_t;

endpackage

/* src/mul_unit.sv */
// iterative unsigned shift-add multiplier
// retires MUL_RADIX_BITS multiplier bits per cycle into a 128-bit accumulator
// holds the finished result until the writeback bus grants it

module mul_unit
    import exe_pkg::*;
#(
    parameter int MUL_RADIX_BITS = 2
) (
    input  logic          clk_i,
    input  logic          arst_n_i,
    input  rr_exe_instr_t instr_i,
    input  logic          grant_i,
    output logic          busy_o,
    output exe_wb_instr_t wb_o
);

    localparam int STEPS = XLEN / MUL_RADIX_BITS;   // latency in cycles
    localparam int CNT_W = $clog2(STEPS);
    localparam int PP_W  = XLEN + MUL_RADIX_BITS;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } mul_state_t;

    mul_state_t                state_q;
    logic [CNT_W-1:0]          cnt_q;
    logic [2*XLEN-1:0]         acc_q;     // partial product | remaining multiplier
    rr_exe_instr_t             instr_q;   // operands and metadata
    logic [MUL_RADIX_BITS-1:0] digit;
    logic [PP_W-1:0]           pp;
    logic [PP_W-1:0]           sum;
    logic [2*XLEN-1:0]         acc_next;
    bus64_t                    result;

    assign digit = acc_q[MUL_RADIX_BITS-1:0];

    // add shifted multiplicand once per set digit bit
    always_comb begin
        pp = '0;
        for (int i = 0; i < MUL_RADIX_BITS; i++) begin
            if (digit[i]) begin
                pp = pp + ({{MUL_RADIX_BITS{1'b0}}, instr_q.data_rs1} << i);
            end
        end
        sum = {{MUL_RADIX_BITS{1'b0}}, acc_q[2*XLEN-1:XLEN]} + pp;
    end

    assign acc_next = {sum, acc_q[XLEN-1:MUL_RADIX_BITS]};   // shift right by radix

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (instr_i.valid) begin
                        state_q <= RUN;
                        cnt_q   <= '0;
                    end
                end
                RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(STEPS - 1)) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    if (grant_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && instr_i.valid) begin
            instr_q <= instr_i;
            acc_q   <= {{XLEN{1'b0}}, instr_i.data_rs2};
        end else if (state_q == RUN) begin
            acc_q <= acc_next;
        end
    end

    // low 32 bits of the full product equal those of the low-word product
    always_comb begin
        case (instr_q.instr_type)
            MULHU:   result = acc_q[2*XLEN-1:XLEN];
            MULW:    result = {{32{acc_q[31]}}, acc_q[31:0]};
            default: result = acc_q[XLEN-1:0];   // MUL
        endcase
    end

    assign busy_o = (state_q != IDLE);   // start until grant

    always_comb begin
        wb_o.valid      = (state_q == DONE);
        wb_o.pc         = instr_q.pc;
        wb_o.rd         = instr_q.rd;
        wb_o.regfile_we = instr_q.regfile_we;
        wb_o.gl_index   = instr_q.gl_index;
        wb_o.instr_type = instr_q.instr_type;
        wb_o.result     = result;
    end

endmodule

/* src/wb_arbiter.sv */
// writeback arbiter of the execution cluster
// one-entry ALU result slot and round-robin grant of the shared bus

module wb_arbiter
    import exe_pkg::*;
(
    input  logic          clk_i,
    input  logic          arst_n_i,
    input  exe_wb_instr_t alu_wb_i,
    input  exe_wb_instr_t mul_wb_i,
    output logic          alu_slot_free_o,
    output logic          mul_grant_o,
    output exe_wb_instr_t wb_o
);

    exe_wb_instr_t slot_q;
    logic          slot_valid_q;
    logic          prio_mul_q;    // set when the multiplier goes first
    logic          alu_req;
    logic          mul_req;
    logic          alu_grant;
    logic          mul_grant;

    assign alu_req = slot_valid_q;
    assign mul_req = mul_wb_i.valid;

    assign alu_grant = alu_req & (~mul_req | ~prio_mul_q);
    assign mul_grant = mul_req & (~alu_req | prio_mul_q);

    assign mul_grant_o     = mul_grant;
    assign alu_slot_free_o = ~slot_valid_q | alu_grant;   // empty or leaving now

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slot_valid_q <= 1'b0;
            prio_mul_q   <= 1'b0;   // ALU first out of reset
        end else begin
            if (alu_wb_i.valid) begin
                slot_valid_q <= 1'b1;
            end else if (alu_grant) begin
                slot_valid_q <= 1'b0;
            end

            // the loser of a contended cycle wins the next one
            if (alu_req && mul_req) begin
                prio_mul_q <= alu_grant;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alu_wb_i.valid) begin
            slot_q <= alu_wb_i;
        end
    end

    always_comb begin
        if (alu_grant) begin
            wb_o = slot_q;
        end else if (mul_grant) begin
            wb_o = mul_wb_i;
        end else begin
            wb_o = '0;
        end
        wb_o.valid = alu_grant | mul_grant;
    end

endmodule

/* test/tb_clk_gen.sv */
// testbench clock and reset generator
// free running clock, active low reset released on a falling edge

module tb_clk_gen #(
    parameter int PERIOD     = 10,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);   // away from the rising edge
        arst_n_o = 1'b1;
    end

endmodule

/* test/tb_exe_cluster.sv */
// testbench of the integer execution cluster
// directed tests, reference model, check task and final report

module tb_exe_cluster;
    import exe_pkg::*;

    localparam int MUL_LAT  = 32;    // 64 / MUL_RADIX_BITS
    localparam int WAIT_MAX = 200;   // cycles without progress

    logic          clk;
    logic          arst_n;
    logic          stall;
    rr_exe_instr_t rr_instr;
    exe_wb_instr_t wb;

    exe_wb_instr_t got_rec [64];     // last record per tag
    int            got_cnt [64];
    int            arr_cycle [64];
    rr_exe_instr_t stream [40];
    int            cycle_cnt;
    int            sample_cycle;     // edge that took the last instruction
    int            errors;
    int            checks;
    int            tag;
    logic          stall_seen;
    unit_t         last_unit;        // unit of the instruction now in dispatch

    tb_clk_gen #(.PERIOD(10), .RST_CYCLES(5)) i_clk_gen (.clk_o(clk), .arst_n_o(arst_n));

    exe_cluster #(
        .MUL_RADIX_BITS (2)
    ) i_dut (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .rr_instr_i (rr_instr),
        .stall_o    (stall),
        .wb_o       (wb)
    );

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic bus64_t rand64();
        return {$urandom(), $urandom()};
    endfunction

    function automatic bus64_t sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // expected result from the RV64I rules
    function automatic bus64_t model_result(input rr_exe_instr_t ins);
        logic [127:0] prod;
        bus64_t       a;
        bus64_t       b;
        a    = ins.data_rs1;
        b    = ins.data_rs2;
        prod = {64'b0, a} * {64'b0, b};
        if (ins.unit == UNIT_MUL) begin
            case (ins.instr_type)
                MULHU:   return prod[127:64];
                MULW:    return sext32(a[31:0] * b[31:0]);
                default: return prod[63:0];
            endcase
        end
        case (ins.instr_type)
            ADD:     return a + b;
            ADDW:    return sext32(a[31:0] + b[31:0]);
            SUB:     return a - b;
            SUBW:    return sext32(a[31:0] - b[31:0]);
            SLL:     return a << b[5:0];
            SLLW:    return sext32(a[31:0] << b[4:0]);
            SLT:     return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            SLTU:    return (a < b) ? 64'd1 : 64'd0;
            XOR:     return a ^ b;
            SRL:     return a >> b[5:0];
            SRLW:    return sext32(a[31:0] >> b[4:0]);
            SRA:     return bus64_t'($signed(a) >>> b[5:0]);
            SRAW:    return sext32(32'($signed(a[31:0]) >>> b[4:0]));
            OR:      return a | b;
            AND:     return a & b;
            default: return (ins.unit == UNIT_SYSTEM) ? a : 64'd0;   // rs1 for csr
        endcase
    endfunction

    // metadata derived from a running tag
    function automatic rr_exe_instr_t make_instr(input unit_t u, input instr_type_t op,
                                                 input bus64_t a, input bus64_t b);
        rr_exe_instr_t ins;
        ins            = '0;
        ins.valid      = 1'b1;
        ins.unit       = u;
        ins.instr_type = op;
        ins.pc         = 40'h80_0000_0000 + 40'(tag * 4);
        ins.rd         = reg_t'(tag % 31 + 1);
        ins.regfile_we = ~tag[0];
        ins.gl_index   = gl_index_t'(tag);
        ins.data_rs1   = a;
        ins.data_rs2   = b;
        tag            = (tag + 1) % 64;
        return ins;
    endfunction

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int err0);
        $display("test %-8s done, %0d errors", name, errors - err0);
    endtask

    task automatic clear_records();
        for (int i = 0; i < 64; i++) begin
            got_cnt[i] = 0;
        end
    endtask

    // holds the instruction until an edge with stall_o low takes it
    task automatic send(input rr_exe_instr_t ins);
        int waited;
        waited = 0;
        @(negedge clk);
        rr_instr = ins;
        while (stall) begin
            if (last_unit == UNIT_MUL) stall_seen = 1'b1;   // a MUL waits in dispatch
            @(negedge clk);
            waited++;
            if (waited > WAIT_MAX) abort_run("stall_o stayed high, instruction never taken");
        end
        sample_cycle = cycle_cnt + 1;
        last_unit    = ins.unit;
    endtask

    task automatic drive_idle();
        @(negedge clk);
        rr_instr.valid = 1'b0;
    endtask

    task automatic collect(input int n);
        int seen;
        int idle;
        seen = 0;
        idle = 0;
        while (seen < n) begin
            @(negedge clk);
            if (wb.valid) begin
                got_rec[wb.gl_index]   = wb;
                got_cnt[wb.gl_index]   = got_cnt[wb.gl_index] + 1;
                arr_cycle[wb.gl_index] = cycle_cnt;
                seen++;
                idle = 0;
            end else begin
                idle++;
                if (idle > WAIT_MAX) abort_run("writeback never came for a sent instruction");
            end
        end
    endtask

    task automatic check_record(input rr_exe_instr_t ins);
        exe_wb_instr_t rec;
        int            t;
        t   = int'(ins.gl_index);
        rec = got_rec[t];
        check_val("wb_o count per tag", 64'(got_cnt[t]), 64'd1);
        check_val("wb_o.result", rec.result, model_result(ins));
        check_val("wb_o.pc", 64'(rec.pc), 64'(ins.pc));
        check_val("wb_o.rd", 64'(rec.rd), 64'(ins.rd));
        check_val("wb_o.regfile_we", 64'(rec.regfile_we), 64'(ins.regfile_we));
        check_val("wb_o.gl_index", 64'(rec.gl_index), 64'(ins.gl_index));
        check_val("wb_o.instr_type", 64'(rec.instr_type), 64'(ins.instr_type));
    endtask

    // one instruction alone in the cluster, latency counted from the taking edge
    task automatic run_one(input rr_exe_instr_t ins, input int lat);
        clear_records();
        send(ins);
        drive_idle();
        collect(1);
        check_record(ins);
        check_val("wb_o latency", 64'(arr_cycle[ins.gl_index] - sample_cycle), 64'(lat));
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        for (int n = 0; n < 10; n++) begin
            @(negedge clk);
            check_val("wb_o.valid", 64'(wb.valid), 64'd0);
            check_val("stall_o", 64'(stall), 64'd0);
        end
        if (!arst_n) abort_run("reset still asserted after 10 cycles");
        end_test("reset", err0);
    endtask

    task automatic test_alu_ops();
        bus64_t dir_a [5] = '{64'h8000_0000_7FFF_FFFF, 64'hF0F0_1234_8765_4321,
                              64'hFFFF_FFFF_FFFF_FFFF, 64'h0000_0000_7FFF_FFFF, 64'd5};
        bus64_t dir_b [5] = '{64'd31, 64'd32, 64'd63, 64'd1, 64'd9};
        bus64_t a;
        bus64_t b;
        int     err0;
        err0 = errors;
        for (int k = 0; k < 15; k++) begin      // ADD through AND
            for (int p = 0; p < 9; p++) begin
                a = (p < 5) ? dir_a[p] : rand64();
                b = (p < 5) ? dir_b[p] : rand64();
                run_one(make_instr(UNIT_ALU, instr_type_t'(k), a, b), 1);
            end
        end
        end_test("alu", err0);
    endtask

    task automatic test_system();
        int err0;
        err0 = errors;
        run_one(make_instr(UNIT_SYSTEM, CSRRW, rand64(), rand64()), 1);
        run_one(make_instr(UNIT_ALU, MUL, rand64(), rand64()), 1);    // not an ALU op
        run_one(make_instr(UNIT_ALU, CSRRW, rand64(), rand64()), 1);
        end_test("system", err0);
    endtask

    task automatic test_mul();
        instr_type_t op;
        int          err0;
        err0 = errors;
        for (int k = 0; k < 3; k++) begin
            op = instr_type_t'(int'(MUL) + k);
            run_one(make_instr(UNIT_MUL, op, '1, '1), 1 + MUL_LAT);
            for (int p = 0; p < 3; p++) begin
                run_one(make_instr(UNIT_MUL, op, rand64(), rand64()), 1 + MUL_LAT);
            end
        end
        end_test("mul", err0);
    endtask

    task automatic test_mixed();
        instr_type_t op;
        int          err0;
        int          r;
        logic        early;
        err0       = errors;
        tag        = 0;
        stall_seen = 1'b0;
        early      = 1'b0;
        for (int i = 0; i < 40; i++) begin
            r = int'($urandom_range(9, 0));
            if (r < 3 || (i >= 8 && i <= 10) || i == 25 || i == 26) begin
                op        = instr_type_t'(int'(MUL) + int'($urandom_range(2, 0)));
                stream[i] = make_instr(UNIT_MUL, op, rand64(), rand64());
            end else if (r == 3) begin
                stream[i] = make_instr(UNIT_SYSTEM, CSRRW, rand64(), rand64());
            end else begin
                op        = instr_type_t'($urandom_range(14, 0));
                stream[i] = make_instr(UNIT_ALU, op, rand64(), rand64());
            end
        end
        clear_records();
        fork
            begin
                for (int i = 0; i < 40; i++) begin
                    send(stream[i]);
                end
                drive_idle();
            end
            collect(40);
        join
        for (int i = 0; i < 40; i++) begin
            check_record(stream[i]);
            for (int j = i + 1; j < 40; j++) begin
                if (stream[i].unit == UNIT_MUL && stream[j].unit != UNIT_MUL &&
                    arr_cycle[j] < arr_cycle[i]) early = 1'b1;
            end
        end
        if (!stall_seen) begin
            errors++;
            $display("ERROR: stall_o never rose while a second MUL waited");
        end
        if (!early) begin
            errors++;
            $display("ERROR: no ALU result overtook an earlier MUL");
        end
        end_test("mixed", err0);
    endtask

    initial begin
        rr_instr     = '0;
        cycle_cnt    = 0;
        sample_cycle = 0;
        errors       = 0;
        checks       = 0;
        tag          = 0;
        stall_seen   = 1'b0;
        last_unit    = UNIT_ALU;
        void'($urandom(31));
        test_reset();
        test_alu_ops();
        test_system();
        test_mul();
        test_mixed();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
